//--- i2c_pkg.sv
/*
 * Shared constants and types for the I2C master.
 * The bus timing assumes a 25 MHz system clock and a 250 kHz scl.
 * Only one slave device address is supported, fixed at build time.
 */
package i2c_pkg;

    // **************************************************
    // bus constants
    // **************************************************
    localparam logic [6:0] slave_addr  = 7'h50;            // 7-bit device address
    localparam int         clk_freq    = 25_000_000;       // system clock in Hz
    localparam int         i2c_freq    = 250_000;          // scl rate in Hz
    localparam int         quarter_div = clk_freq / (4 * i2c_freq); // cycles per quarter bit
    localparam int         tick_cnt_w  = $clog2(quarter_div);

    localparam int addr_w = 16;                            // word address width
    localparam int data_w = 8;                             // data width

    // ticks per bit-engine opcode
    localparam int start_ticks   = 2;
    localparam int restart_ticks = 4;
    localparam int stop_ticks    = 4;
    localparam int byte_ticks    = 36;                     // 8 data bits + ack bit

    // **************************************************
    // enums
    // **************************************************
    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_dev_wr,
        st_addr_hi,
        st_addr_lo,
        st_data_wr,
        st_restart,
        st_dev_rd,
        st_data_rd,
        st_stop
    } i2c_state_e;

    typedef enum logic [2:0] {
        op_start,
        op_restart,
        op_write,
        op_read,
        op_stop
    } byte_op_e;

    // **************************************************
    // structs
    // **************************************************
    typedef struct packed {
        logic              rd;                             // 1 = read
        logic              addr16;                         // 1 = two address bytes
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } i2c_req_t;

    typedef struct packed {
        byte_op_e          op;
        logic [data_w-1:0] data;                           // byte to send
    } byte_cmd_t;

    typedef struct packed {
        logic              nack;                           // sampled ack bit
        logic [data_w-1:0] rdata;                          // byte received
    } byte_rsp_t;

endpackage

//--- i2c_tick_gen.sv
/*
 * Quarter-bit timing base for the I2C bus.
 * tick is high for one system cycle every quarter_div cycles.
 */
`timescale 1ns/1ps

module i2c_tick_gen (
    input  logic dri_clk,
    input  logic rst_n,
    output logic tick
);
    import i2c_pkg::*;

    logic [tick_cnt_w-1:0] cnt;
    logic                  wrap;

    assign wrap = (cnt == tick_cnt_w'(quarter_div - 1));

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= wrap;                                   // one pulse per wrap
            if (wrap)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- i2c_sequencer.sv
/*
 * Transfer FSM for single-byte random access.
 * A request is taken only in idle; exec while busy is dropped.
 * A missing acknowledge does not abort the transfer, it only sets ack_err.
 * rdata holds the last byte read until the next read completes.
 */
`timescale 1ns/1ps

module i2c_sequencer (
    input  logic                        dri_clk,
    input  logic                        rst_n,
    input  logic                        exec,
    input  i2c_pkg::i2c_req_t           req,
    output logic                        busy,
    output logic                        done,
    output logic [i2c_pkg::data_w-1:0]  rdata,
    output logic                        ack_err,
    output logic                        cmd_valid,
    output i2c_pkg::byte_cmd_t          cmd,
    input  logic                        rsp_valid,
    input  i2c_pkg::byte_rsp_t          rsp
);
    import i2c_pkg::*;

    i2c_state_e state;
    i2c_state_e state_nxt;
    i2c_req_t   req_q;
    byte_cmd_t  cmd_nxt;
    logic       launch;                                     // state just changed
    logic       wr_byte;                                    // slave must ack this byte
    logic       accept;

    assign busy    = (state != st_idle);
    assign accept  = (state == st_idle) && exec;
    assign wr_byte = state inside {st_dev_wr, st_addr_hi, st_addr_lo, st_data_wr, st_dev_rd};

    // **************************************************
    // state walk
    // **************************************************
    always_comb begin
        state_nxt = st_idle;
        case (state)
            st_start:   state_nxt = st_dev_wr;
            st_dev_wr:  state_nxt = req_q.addr16 ? st_addr_hi : st_addr_lo;
            st_addr_hi: state_nxt = st_addr_lo;
            st_addr_lo: state_nxt = req_q.rd ? st_restart : st_data_wr;
            st_data_wr: state_nxt = st_stop;
            st_restart: state_nxt = st_dev_rd;
            st_dev_rd:  state_nxt = st_data_rd;
            st_data_rd: state_nxt = st_stop;
            default:    state_nxt = st_idle;                // stop and idle
        endcase
    end

    // byte command for the current state
    always_comb begin
        cmd_nxt.op   = op_stop;
        cmd_nxt.data = '1;
        case (state)
            st_start:   cmd_nxt.op = op_start;
            st_dev_wr: begin
                cmd_nxt.op   = op_write;
                cmd_nxt.data = {slave_addr, 1'b0};          // write direction
            end
            st_addr_hi: begin
                cmd_nxt.op   = op_write;
                cmd_nxt.data = req_q.addr[15:8];
            end
            st_addr_lo: begin
                cmd_nxt.op   = op_write;
                cmd_nxt.data = req_q.addr[7:0];
            end
            st_data_wr: begin
                cmd_nxt.op   = op_write;
                cmd_nxt.data = req_q.wdata;
            end
            st_restart: cmd_nxt.op = op_restart;
            st_dev_rd: begin
                cmd_nxt.op   = op_write;
                cmd_nxt.data = {slave_addr, 1'b1};          // read direction
            end
            st_data_rd: cmd_nxt.op = op_read;
            default:    cmd_nxt.op = op_stop;
        endcase
    end

    // **************************************************
    // control
    // **************************************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            launch    <= 1'b0;
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            ack_err   <= 1'b0;
        end else begin
            launch    <= 1'b0;
            cmd_valid <= launch;                            // one cycle after state change
            done      <= 1'b0;
            if (accept) begin
                state   <= st_start;
                launch  <= 1'b1;
                ack_err <= 1'b0;
            end else if (busy && rsp_valid) begin
                state <= state_nxt;
                if (state_nxt == st_idle)
                    done <= 1'b1;                           // stop finished
                else
                    launch <= 1'b1;
                if (wr_byte)
                    ack_err <= ack_err | rsp.nack;
            end
        end
    end

    // request, read byte and command payload
    always_ff @(posedge dri_clk) begin
        if (accept)
            req_q <= req;
        if (rsp_valid && state == st_data_rd)
            rdata <= rsp.rdata;
        if (launch)
            cmd <= cmd_nxt;
    end

endmodule

//--- i2c_bit_engine.sv
/*
 * Runs one byte command on scl and sda in quarter-bit steps.
 * A command starts on the first tick after cmd_valid.
 * sda_in is sampled directly, so it must be synchronous to dri_clk.
 * The read byte always ends with a not-acknowledge.
 */
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                dri_clk,
    input  logic                rst_n,
    input  logic                tick,
    input  logic                cmd_valid,
    input  i2c_pkg::byte_cmd_t  cmd,
    output logic                rsp_valid,
    output i2c_pkg::byte_rsp_t  rsp,
    output logic                scl,
    output logic                sda_drive_low,
    input  logic                sda_in
);
    import i2c_pkg::*;

    byte_op_e          op_q;
    logic [data_w-1:0] shreg;                               // tx or rx byte
    logic              nack_q;
    logic              active;
    logic [5:0]        step;                                // quarter-step counter
    logic [5:0]        last_step;
    logic [3:0]        bit_idx;
    logic [1:0]        qtr;
    logic              run;
    logic              is_byte;

    assign run     = active && tick;
    assign bit_idx = step[5:2];
    assign qtr     = step[1:0];
    assign is_byte = (op_q == op_write) || (op_q == op_read);

    assign rsp.nack  = nack_q;
    assign rsp.rdata = shreg;

    always_comb begin
        case (op_q)
            op_start:   last_step = 6'(start_ticks - 1);
            op_restart: last_step = 6'(restart_ticks - 1);
            op_stop:    last_step = 6'(stop_ticks - 1);
            default:    last_step = 6'(byte_ticks - 1);
        endcase
    end

    // **************************************************
    // bus waveform
    // **************************************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            active        <= 1'b0;
            step          <= '0;
            rsp_valid     <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            if (cmd_valid) begin
                active <= 1'b1;                             // wait for next tick
                step   <= '0;
            end else if (run) begin
                step <= step + 1'b1;
                if (step == last_step) begin
                    active    <= 1'b0;
                    rsp_valid <= 1'b1;
                end
                case (op_q)
                    op_start: begin
                        if (step[0] == 1'b0)
                            sda_drive_low <= 1'b1;          // sda falls, scl high
                        else
                            scl <= 1'b0;
                    end
                    op_restart: begin
                        case (qtr)
                            2'd0: sda_drive_low <= 1'b0;
                            2'd1: scl <= 1'b1;
                            2'd2: sda_drive_low <= 1'b1;    // repeated start
                            default: scl <= 1'b0;
                        endcase
                    end
                    op_stop: begin
                        case (qtr)
                            2'd0: sda_drive_low <= 1'b1;
                            2'd1: scl <= 1'b1;
                            2'd2: sda_drive_low <= 1'b0;    // sda rises, scl high
                            default: ;                      // bus idle
                        endcase
                    end
                    default: begin
                        case (qtr)
                            2'd0: begin
                                if (op_q == op_write && bit_idx < 4'd8)
                                    sda_drive_low <= ~shreg[data_w-1];
                                else
                                    sda_drive_low <= 1'b0;  // release for ack or read
                            end
                            2'd1: scl <= 1'b1;
                            2'd2: ;                         // sampled below
                            default: scl <= 1'b0;
                        endcase
                    end
                endcase
            end
        end
    end

    // shift register and ack bit
    always_ff @(posedge dri_clk) begin
        if (cmd_valid) begin
            op_q  <= cmd.op;
            shreg <= cmd.data;
        end else if (run && is_byte) begin
            if (bit_idx == 4'd8) begin
                if (qtr == 2'd2)
                    nack_q <= sda_in;                       // high = no ack
            end else if (op_q == op_read && qtr == 2'd2) begin
                shreg <= {shreg[data_w-2:0], sda_in};       // msb first
            end else if (op_q == op_write && qtr == 2'd3) begin
                shreg <= {shreg[data_w-2:0], 1'b0};
            end
        end
    end

endmodule

//--- i2c_master_top.sv
/*
 * I2C master for one-byte reads and writes at an 8 or 16-bit address.
 * sda is open-drain: the pull-up and wired-AND are outside this block.
 * scl is driven push-pull, so clock stretching is not supported.
 */
`timescale 1ns/1ps

module i2c_master_top (
    input  logic                        dri_clk,
    input  logic                        rst_n,
    input  logic                        exec,
    input  i2c_pkg::i2c_req_t           req,
    output logic                        busy,
    output logic                        done,
    output logic [i2c_pkg::data_w-1:0]  rdata,
    output logic                        ack_err,
    output logic                        scl,
    output logic                        sda_drive_low,
    input  logic                        sda_in
);
    import i2c_pkg::*;

    logic      tick;
    logic      cmd_valid;
    byte_cmd_t cmd;
    logic      rsp_valid;
    byte_rsp_t rsp;

    i2c_tick_gen u_tick_gen (
        .dri_clk (dri_clk),
        .rst_n   (rst_n),
        .tick    (tick)
    );

    i2c_sequencer u_sequencer (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .exec      (exec),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .ack_err   (ack_err),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    i2c_bit_engine u_bit_engine (
        .dri_clk       (dri_clk),
        .rst_n         (rst_n),
        .tick          (tick),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

//--- tb_i2c_slave.sv
/*
 * Behavioral I2C slave for simulation only.
 * Memory is 64K bytes filled with 0xFF; an 8-bit word address selects page 0.
 * The address byte count must be set before each transfer starts.
 * Changes sda only while scl is low, so it never stretches or arbitrates.
 */
`timescale 1ns/1ps

module tb_i2c_slave (
    input  logic       scl,
    input  logic       master_low,
    input  logic [6:0] dev_addr,
    input  logic [1:0] addr_bytes,
    output logic       sda
);
    logic [7:0]  mem [0:65535];
    logic        drive_low;
    logic        listening;                                 // addressed and in a frame
    logic        skip_fall;                                 // scl fall that ends a start
    logic        tx_mode;
    logic        go_tx;
    logic        master_nack;
    logic        scl_q;
    logic        sda_q;
    logic [3:0]  bit_cnt;
    logic [7:0]  sh;
    logic [15:0] ptr;
    int          byte_idx;

    assign sda = ~(master_low | drive_low);                 // wired-AND with pull-up

    task automatic begin_frame();
        listening = 1'b1;
        skip_fall = 1'b1;
        tx_mode   = 1'b0;
        go_tx     = 1'b0;
        bit_cnt   = 4'd0;
        byte_idx  = 0;
        drive_low = 1'b0;
    endtask

    task automatic end_frame();
        listening = 1'b0;
        tx_mode   = 1'b0;
        drive_low = 1'b0;
    endtask

    task automatic sample_bit();
        if (bit_cnt < 4'd8 && !tx_mode)
            sh = {sh[6:0], sda};
        else if (bit_cnt == 4'd8 && tx_mode)
            master_nack = sda;                              // high = master done
    endtask

    task automatic take_byte();
        if (byte_idx == 0) begin
            if (sh[7:1] == dev_addr) begin
                drive_low = 1'b1;
                go_tx     = sh[0];
            end else begin
                listening = 1'b0;                           // not our address
            end
        end else if (byte_idx <= int'(addr_bytes)) begin
            if (byte_idx == 1)
                ptr = {8'h00, sh};
            else
                ptr = {ptr[7:0], sh};
            drive_low = 1'b1;
        end else begin
            mem[ptr]  = sh;
            ptr       = ptr + 16'd1;
            drive_low = 1'b1;
        end
    endtask

    task automatic close_ack_slot();
        bit_cnt   = 4'd0;
        byte_idx  = byte_idx + 1;
        drive_low = 1'b0;
        if (tx_mode) begin
            ptr = ptr + 16'd1;
            if (master_nack) begin
                tx_mode   = 1'b0;
                listening = 1'b0;
            end
        end
        if (go_tx) begin
            tx_mode = 1'b1;
            go_tx   = 1'b0;
        end
        if (tx_mode) begin
            sh        = mem[ptr];
            drive_low = ~sh[7];                             // first bit, msb
        end
    endtask

    task automatic advance_bit();
        if (bit_cnt < 4'd8) begin
            bit_cnt = bit_cnt + 4'd1;
            if (bit_cnt < 4'd8) begin
                if (tx_mode) begin
                    sh        = {sh[6:0], 1'b0};
                    drive_low = ~sh[7];
                end
            end else if (tx_mode) begin
                drive_low = 1'b0;                           // master drives ack
            end else begin
                take_byte();
            end
        end else begin
            close_ack_slot();
        end
    endtask

    // **************************************************
    // bus monitor
    // **************************************************
    initial begin
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'hFF;
        drive_low   = 1'b0;
        listening   = 1'b0;
        skip_fall   = 1'b0;
        tx_mode     = 1'b0;
        go_tx       = 1'b0;
        master_nack = 1'b0;
        bit_cnt     = 4'd0;
        sh          = 8'h00;
        ptr         = 16'h0000;
        byte_idx    = 0;
        scl_q       = 1'b1;
        sda_q       = 1'b1;
        forever begin
            @(scl or sda);
            if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
                begin_frame();                              // start or restart
            else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
                end_frame();                                // stop
            else if (scl === 1'b1 && scl_q === 1'b0 && listening && !skip_fall)
                sample_bit();
            else if (scl === 1'b0 && scl_q === 1'b1 && listening) begin
                if (skip_fall)
                    skip_fall = 1'b0;
                else
                    advance_bit();
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

//--- tb_i2c_master.sv
/*
 * Testbench for the I2C master with a behavioral slave on an open-drain bus.
 * Expected read data comes from a shadow of every acknowledged write.
 * Each wait for done is bounded by wait_limit cycles.
 */
`timescale 1ns/1ps

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int wait_limit = 10000;                      // cycles per transfer

    logic              dri_clk;
    logic              rst_n;
    logic              exec;
    i2c_req_t          req;
    logic              busy;
    logic              done;
    logic [data_w-1:0] rdata;
    logic              ack_err;
    logic              scl;
    logic              sda_drive_low;
    logic              sda_in;
    logic [6:0]        slv_dev_addr;
    logic [1:0]        slv_addr_bytes;

    logic [7:0]        shadow [int];                        // last write per address
    int                seed;
    int                done_count = 0;
    int                cmp_errors = 0;
    int                stim_errors;
    int                tests_run;
    int                tests_failed;
    logic              exp_rd;
    logic [7:0]        exp_rdata;
    logic              exp_ack_err;

    i2c_master_top dut (
        .dri_clk       (dri_clk),
        .rst_n         (rst_n),
        .exec          (exec),
        .req           (req),
        .busy          (busy),
        .done          (done),
        .rdata         (rdata),
        .ack_err       (ack_err),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    tb_i2c_slave slave (
        .scl        (scl),
        .master_low (sda_drive_low),
        .dev_addr   (slv_dev_addr),
        .addr_bytes (slv_addr_bytes),
        .sda        (sda_in)
    );

    initial begin
        dri_clk = 1'b0;
        forever #20 dri_clk = ~dri_clk;                     // 25 MHz
    end

    // **************************************************
    // reference model
    // **************************************************
    function automatic logic [15:0] eff_addr(input i2c_req_t r);
        if (r.addr16)
            return r.addr;
        return {8'h00, r.addr[7:0]};                        // one address byte, page 0
    endfunction

    function automatic logic [7:0] ref_read(input logic [15:0] a);
        if (shadow.exists(int'(a)))
            return shadow[int'(a)];
        return 8'hFF;                                       // slave fill value
    endfunction

    function automatic i2c_req_t make_req(input logic rd, input logic addr16,
                                          input logic [15:0] addr, input logic [7:0] wdata);
        i2c_req_t r;
        r.rd     = rd;
        r.addr16 = addr16;
        r.addr   = addr;
        r.wdata  = wdata;
        return r;
    endfunction

    function automatic int error_total();
        return cmp_errors + stim_errors;
    endfunction

    // compare at every done
    always @(negedge dri_clk) begin
        if (rst_n === 1'b1 && done === 1'b1) begin
            done_count = done_count + 1;
            if (ack_err !== exp_ack_err) begin
                $display("ERR %0t: ack_err %b, expected %b", $time, ack_err, exp_ack_err);
                cmp_errors = cmp_errors + 1;
            end
            if (exp_rd && rdata !== exp_rdata) begin
                $display("ERR %0t: rdata %h, expected %h", $time, rdata, exp_rdata);
                cmp_errors = cmp_errors + 1;
            end
        end
    end

    // **************************************************
    // stimulus tasks
    // **************************************************
    task automatic start_xfer(input i2c_req_t r, input logic exp_err);
        @(negedge dri_clk);
        slv_addr_bytes = r.addr16 ? 2'd2 : 2'd1;
        exp_rd         = r.rd;
        exp_rdata      = ref_read(eff_addr(r));
        exp_ack_err    = exp_err;
        req            = r;
        exec           = 1'b1;
        @(negedge dri_clk);
        exec = 1'b0;
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < wait_limit) begin
            @(posedge dri_clk);
            cycles = cycles + 1;
        end
        if (done_count < target) begin
            $display("timeout: no done within %0d cycles at %0t", wait_limit, $time);
            stim_errors = stim_errors + 1;
        end
    endtask

    task automatic run_xfer(input i2c_req_t r, input logic exp_err);
        int target;
        target = done_count + 1;
        start_xfer(r, exp_err);
        wait_done(target);
        if (!r.rd && !exp_err)
            shadow[int'(eff_addr(r))] = r.wdata;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run = tests_run + 1;
        if (error_total() != err_before) begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // **************************************************
    // test sequence
    // **************************************************
    initial begin
        int         base;
        int         target;
        logic [31:0] rnd;
        seed           = 99;
        rst_n          = 1'b0;
        exec           = 1'b0;
        req            = '0;
        slv_dev_addr   = slave_addr;
        slv_addr_bytes = 2'd1;
        exp_rd         = 1'b0;
        exp_rdata      = 8'h00;
        exp_ack_err    = 1'b0;
        stim_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (10) @(posedge dri_clk);
        @(negedge dri_clk);
        rst_n = 1'b1;

        base = error_total();
        repeat (3) @(negedge dri_clk);
        if (scl !== 1'b1 || sda_drive_low !== 1'b0) begin
            $display("ERR %0t: bus not idle, scl %b sda_drive_low %b", $time, scl,
                     sda_drive_low);
            stim_errors = stim_errors + 1;
        end
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("ERR %0t: busy %b done %b after reset", $time, busy, done);
            stim_errors = stim_errors + 1;
        end
        finish_test("reset levels", base);

        base = error_total();
        run_xfer(make_req(1'b0, 1'b0, 16'h003C, 8'hA5), 1'b0);
        run_xfer(make_req(1'b1, 1'b0, 16'h003C, 8'h00), 1'b0);
        finish_test("8-bit address write and read", base);

        base = error_total();
        run_xfer(make_req(1'b0, 1'b1, 16'h1234, 8'h5A), 1'b0);
        run_xfer(make_req(1'b1, 1'b1, 16'h1234, 8'h00), 1'b0);
        run_xfer(make_req(1'b1, 1'b1, 16'h1334, 8'h00), 1'b0);   // other high byte
        run_xfer(make_req(1'b1, 1'b0, 16'h0034, 8'h00), 1'b0);
        finish_test("16-bit address write and read", base);

        base = error_total();
        for (int i = 0; i < 20; i++) begin
            rnd = $random(seed);
            run_xfer(make_req(rnd[0], rnd[1], rnd[31:16] & 16'h0107, rnd[15:8]), 1'b0);
        end
        finish_test("random operations", base);

        base = error_total();
        @(negedge dri_clk);
        slv_dev_addr = slave_addr ^ 7'h01;                  // slave no longer matches
        run_xfer(make_req(1'b0, 1'b0, 16'h003C, 8'h00), 1'b1);
        @(negedge dri_clk);
        slv_dev_addr = slave_addr;
        run_xfer(make_req(1'b1, 1'b0, 16'h003C, 8'h00), 1'b0);
        finish_test("device address mismatch", base);

        base   = error_total();
        target = done_count + 1;
        start_xfer(make_req(1'b0, 1'b0, 16'h0077, 8'h11), 1'b0);
        repeat (4) @(negedge dri_clk);
        if (busy !== 1'b1) begin
            $display("ERR %0t: busy %b during transfer", $time, busy);
            stim_errors = stim_errors + 1;
        end
        req  = make_req(1'b0, 1'b0, 16'h0077, 8'h22);
        exec = 1'b1;
        @(negedge dri_clk);
        exec = 1'b0;
        wait_done(target);
        shadow[int'(16'h0077)] = 8'h11;
        repeat (100) @(negedge dri_clk);
        if (done_count != target || busy !== 1'b0) begin
            $display("ERR %0t: %0d done strobes, busy %b, expected one done and idle",
                     $time, done_count - target + 1, busy);
            stim_errors = stim_errors + 1;
        end
        run_xfer(make_req(1'b1, 1'b0, 16'h0077, 8'h00), 1'b0);
        finish_test("exec while busy", base);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 error_total());
        if (error_total() == 0 && tests_failed == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- src.f
i2c_pkg.sv
i2c_tick_gen.sv
i2c_sequencer.sv
i2c_bit_engine.sv
i2c_master_top.sv
tb_i2c_slave.sv
tb_i2c_master.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the I2C master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_i2c_master -o tb_i2c_master

out=$(./obj_dir/tb_i2c_master)
echo "$out"

if grep -qF '** PASS **' <<< "$out"; then
    exit 0
fi
exit 1
